// ==== rtl/ex_defines.svh ====
//////////////////////////////////////////////////
// Shared widths of the execute stage
// The mul and div datapaths are sized for a
// 32-bit word, so EX_XLEN must stay at 32
//////////////////////////////////////////////////

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data word
`define EX_XLEN 32
// Destination register address
`define EX_RADDR_W 5
// Op field, shared by ALU and mul/div encodings
`define EX_OP_W 4

`endif

// ==== rtl/ex_pkg.sv ====
//////////////////////////////////////////////////
// Types of the execute stage
// The op word is decoded by the unit select
//////////////////////////////////////////////////

`include "ex_defines.svh"

package ex_pkg;

  // Functional unit select
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } ex_unit_e;

  // ALU operators, compares last
  typedef enum logic [`EX_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE
  } alu_op_e;

  // Mul/div operator, upper bits unused
  typedef struct packed {
    logic [1:0] pad;
    logic [1:0] md_sel;
  } md_op_t;

  // md_sel meaning with UNIT_MUL
  localparam logic [1:0] MD_MUL    = 2'd0;
  localparam logic [1:0] MD_MULH   = 2'd1;
  localparam logic [1:0] MD_MULHSU = 2'd2;
  localparam logic [1:0] MD_MULHU  = 2'd3;
  // md_sel meaning with UNIT_DIV
  localparam logic [1:0] MD_DIV    = 2'd0;
  localparam logic [1:0] MD_DIVU   = 2'd1;
  localparam logic [1:0] MD_REM    = 2'd2;
  localparam logic [1:0] MD_REMU   = 2'd3;

  // One op word, two readings
  typedef union packed {
    alu_op_e alu;
    md_op_t  md;
  } ex_op_u;

endpackage

// ==== rtl/div_alu_if.sv ====
//////////////////////////////////////////////////
// Divider access to the ALU shifter and CLZ
// Results are combinational, in the request cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

interface div_alu_if;

  // Requests from the divider
  logic               shift_en;
  logic [5:0]         shift_amt;
  logic               clz_en;
  logic [`EX_XLEN-1:0] clz_data;
  // Answers from the ALU
  logic [`EX_XLEN-1:0] shifted;
  logic [5:0]         clz_result;

  modport requester (output shift_en, shift_amt, clz_en, clz_data,
                     input  shifted, clz_result);
  modport server    (input  shift_en, shift_amt, clz_en, clz_data,
                     output shifted, clz_result);

endinterface

// ==== rtl/ex_alu.sv ====
//////////////////////////////////////////////////
// Single-cycle ALU with compare flag
// Shifter and CLZ are lent to the divider, which
// only asks while no ALU op is in flight
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_alu (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::alu_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o,
  div_alu_if.server           div_if
);
  import ex_pkg::*;

  logic                use_sub;
  logic [`EX_XLEN-1:0] adder_res;
  logic                is_eq;
  logic                lt_s;
  logic                lt_u;
  logic [`EX_XLEN-1:0] sh_in;
  logic [5:0]          sh_amt;
  logic [`EX_XLEN-1:0] sh_left;
  logic [`EX_XLEN-1:0] sh_right;
  logic [`EX_XLEN-1:0] sh_arith;
  logic [`EX_XLEN-1:0] clz_in;
  logic [5:0]          clz_cnt;
  logic [5:0]          clz_hold_q;

  // One adder subtracts by inverting b and carrying in
  assign use_sub   = (operator_i == ALU_SUB);
  assign adder_res = operand_a_i + (use_sub ? ~operand_b_i : operand_b_i)
                     + `EX_XLEN'(use_sub);

  assign is_eq = (operand_a_i == operand_b_i);
  assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u  = (operand_a_i < operand_b_i);

  ////////////////////////////////////////////////
  // Shared shifter and leading-zero count
  ////////////////////////////////////////////////

  // Divider request overrides the operands
  assign sh_in    = div_if.shift_en ? div_if.clz_data : operand_a_i;
  assign sh_amt   = div_if.shift_en ? div_if.shift_amt : {1'b0, operand_b_i[4:0]};
  assign sh_left  = sh_in << sh_amt;
  assign sh_right = sh_in >> sh_amt;
  assign sh_arith = $unsigned($signed(sh_in) >>> sh_amt);
  assign div_if.shifted = sh_left;

  assign clz_in = div_if.clz_en ? div_if.clz_data : operand_a_i;

  // Highest set bit wins and a zero word counts 32
  always_comb begin
    clz_cnt = 6'd32;
    for (int i = 0; i < `EX_XLEN; i++) begin
      if (clz_in[i]) clz_cnt = 6'(`EX_XLEN - 1 - i);
    end
  end

  // Count is kept so the divider can read it during its loop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clz_hold_q <= '0;
    end else if (div_if.clz_en) begin
      clz_hold_q <= clz_cnt;
    end
  end

  assign div_if.clz_result = div_if.clz_en ? clz_cnt : clz_hold_q;

  // Result and compare select
  always_comb begin
    result_o     = adder_res;
    cmp_result_o = 1'b0;
    case (operator_i)
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = sh_left;
      ALU_SRL:  result_o = sh_right;
      ALU_SRA:  result_o = sh_arith;
      ALU_SLT:  cmp_result_o = lt_s;
      ALU_SLTU: cmp_result_o = lt_u;
      ALU_EQ:   cmp_result_o = is_eq;
      ALU_NE:   cmp_result_o = !is_eq;
      // Add and subtract keep the adder result
      default: ;
    endcase
    // Compares write the flag as a 0/1 word
    if (operator_i inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE}) begin
      result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    end
  end

endmodule

// ==== rtl/ex_mult.sv ====
//////////////////////////////////////////////////
// Two-cycle multiplier, MUL/MULH/MULHSU/MULHU
// Cycle 0 latches partial products, cycle 1 sums
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::md_op_t      operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                valid_i,
  input  logic                ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                valid_o
);
  import ex_pkg::*;

  logic               sign_a;
  logic               sign_b;
  logic signed [16:0] a_lo, a_hi, b_lo, b_hi;
  logic signed [33:0] pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic signed [63:0] product;
  logic               hi_q;
  logic               busy_q;

  // Operand signedness by form, MUL low word does not care
  assign sign_a = (operator_i.md_sel == MD_MULH) || (operator_i.md_sel == MD_MULHSU);
  assign sign_b = (operator_i.md_sel == MD_MULH);

  // 16-bit halves plus a sign bit
  assign a_lo = {1'b0, op_a_i[15:0]};
  assign a_hi = {sign_a & op_a_i[31], op_a_i[31:16]};
  assign b_lo = {1'b0, op_b_i[15:0]};
  assign b_hi = {sign_b & op_b_i[31], op_b_i[31:16]};

  always_ff @(posedge clk) begin
    if (valid_i && !busy_q) begin
      pp_ll_q <= a_lo * b_lo;
      pp_lh_q <= a_lo * b_hi;
      pp_hl_q <= a_hi * b_lo;
      pp_hh_q <= a_hi * b_hi;
      hi_q    <= (operator_i.md_sel != MD_MUL);
    end
  end

  // Busy until the result is taken or the op is dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= valid_i;
    end else if (!valid_i || ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Product modulo 2^64 is exact for every form
  assign product  = (pp_hh_q <<< 32) + ((pp_lh_q + pp_hl_q) <<< 16) + pp_ll_q;
  assign result_o = hi_q ? product[63:32] : product[31:0];
  assign valid_o  = busy_q;
  assign ready_o  = busy_q ? ready_i : !valid_i;

endmodule

// ==== rtl/ex_div.sv ====
//////////////////////////////////////////////////
// Shift-subtract divider and remainder
// Latency depends on the divisor's leading zeros
// Dropping valid_i aborts a running divide
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_div (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::md_op_t      operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                valid_i,
  input  logic                ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                valid_o,
  div_alu_if.requester        alu_if
);
  import ex_pkg::*;

  typedef enum logic [1:0] {IDLE, CLZ, DIVIDE, FINISH} div_state_e;

  div_state_e          state_q;
  logic [5:0]          iter_q;
  logic                sign_op;
  logic                a_neg, b_neg;
  logic [`EX_XLEN-1:0] a_mag, b_mag;
  logic                div_zero;
  logic                overflow;
  logic [`EX_XLEN-1:0] rem_q, dvs_q, quo_q;
  logic                neg_quo_q, neg_rem_q, is_rem_q;
  logic                rem_ge;

  // DIV and REM are the signed forms
  assign sign_op  = (operator_i.md_sel == MD_DIV) || (operator_i.md_sel == MD_REM);
  assign a_neg    = sign_op & op_a_i[`EX_XLEN-1];
  assign b_neg    = sign_op & op_b_i[`EX_XLEN-1];
  assign a_mag    = a_neg ? -op_a_i : op_a_i;
  assign b_mag    = b_neg ? -op_b_i : op_b_i;
  assign div_zero = (op_b_i == '0);
  assign overflow = sign_op && (op_a_i == {1'b1, {(`EX_XLEN-1){1'b0}}}) && (&op_b_i);

  ////////////////////////////////////////////////
  // Borrowed ALU logic
  ////////////////////////////////////////////////

  // Count and align the divisor in one cycle
  assign alu_if.clz_en    = (state_q == CLZ);
  assign alu_if.shift_en  = (state_q == CLZ);
  assign alu_if.clz_data  = dvs_q;
  assign alu_if.shift_amt = alu_if.clz_result;

  assign rem_ge = (rem_q >= dvs_q);

  // FSM, any state falls back to IDLE when the op goes away
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      iter_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i) state_q <= (div_zero || overflow) ? FINISH : CLZ;
        end
        CLZ: begin
          iter_q  <= '0;
          state_q <= valid_i ? DIVIDE : IDLE;
        end
        DIVIDE: begin
          iter_q <= iter_q + 6'd1;
          // Quotient has clz+1 bits at most
          if (!valid_i) state_q <= IDLE;
          else if (iter_q == alu_if.clz_result) state_q <= FINISH;
        end
        default: begin
          if (!valid_i || ready_i) state_q <= IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    case (state_q)
      IDLE: begin
        is_rem_q <= (operator_i.md_sel == MD_REM) || (operator_i.md_sel == MD_REMU);
        if (div_zero) begin
          // x / 0 is all ones, x % 0 is x
          quo_q     <= '1;
          rem_q     <= op_a_i;
          neg_quo_q <= 1'b0;
          neg_rem_q <= 1'b0;
        end else if (overflow) begin
          // Most negative / -1 keeps the dividend, remainder zero
          quo_q     <= op_a_i;
          rem_q     <= '0;
          neg_quo_q <= 1'b0;
          neg_rem_q <= 1'b0;
        end else begin
          rem_q     <= a_mag;
          dvs_q     <= b_mag;
          quo_q     <= '0;
          neg_quo_q <= a_neg ^ b_neg;
          neg_rem_q <= a_neg;
        end
      end
      CLZ:    dvs_q <= alu_if.shifted;
      DIVIDE: begin
        // One restoring step per cycle
        if (rem_ge) rem_q <= rem_q - dvs_q;
        quo_q <= {quo_q[`EX_XLEN-2:0], rem_ge};
        dvs_q <= dvs_q >> 1;
      end
      default: ;
    endcase
  end

  // Sign correction, remainder follows the dividend
  assign result_o = is_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                             : (neg_quo_q ? -quo_q : quo_q);
  assign valid_o  = (state_q == FINISH);
  assign ready_o  = (state_q == IDLE) ? !valid_i : ((state_q == FINISH) && ready_i);

endmodule

// ==== rtl/ex_stage.sv ====
//////////////////////////////////////////////////
// Execute stage with ALU, MUL and DIV units
// One op at a time, held by the source until it
// transfers into the EX/WB register
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid_i,
  input  ex_pkg::ex_unit_e       unit_i,
  input  ex_pkg::ex_op_u         op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_RADDR_W-1:0] rd_i,
  input  logic                   kill_i,
  input  logic                   halt_i,
  input  logic                   wb_ready_i,
  output logic                   ex_ready_o,
  output logic                   branch_taken_o,
  output logic                   wb_valid_o,
  output logic [`EX_RADDR_W-1:0] wb_rd_o,
  output logic [`EX_XLEN-1:0]    wb_wdata_o
);
  import ex_pkg::*;

  logic                instr_valid;
  logic                mul_en, div_en;
  logic                alu_ready;
  logic                mul_ready, mul_valid;
  logic                div_ready, div_valid;
  logic                ex_valid;
  logic [`EX_XLEN-1:0] alu_result, mul_result, div_result;
  logic [`EX_XLEN-1:0] ex_result;

  div_alu_if div_alu_bus ();

  // Kill and halt both hold the units off
  assign instr_valid = instr_valid_i && !kill_i && !halt_i;
  assign mul_en      = instr_valid && (unit_i == UNIT_MUL);
  assign div_en      = instr_valid && (unit_i == UNIT_DIV);

  ex_alu u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .operator_i   (op_i.alu),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_taken_o),
    .div_if       (div_alu_bus)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (op_i.md),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_en),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid)
  );

  ex_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (op_i.md),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (div_en),
    .ready_i    (wb_ready_i),
    .result_o   (div_result),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .alu_if     (div_alu_bus)
  );

  // ALU result is ready in the same cycle
  assign alu_ready = wb_ready_i;

  always_comb begin
    case (unit_i)
      UNIT_MUL: begin
        ex_result = mul_result;
        ex_valid  = instr_valid && mul_valid;
      end
      UNIT_DIV: begin
        ex_result = div_result;
        ex_valid  = instr_valid && div_valid;
      end
      default: begin
        ex_result = alu_result;
        ex_valid  = instr_valid;
      end
    endcase
  end

  assign ex_ready_o = kill_i || (alu_ready && mul_ready && div_ready && wb_ready_i && !halt_i);

  ////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= '0;
      wb_wdata_o <= '0;
    end else if (ex_valid && wb_ready_i) begin
      wb_valid_o <= 1'b1;
      wb_rd_o    <= rd_i;
      wb_wdata_o <= ex_result;
    end else if (wb_ready_i) begin
      // Nothing to hand over, insert a bubble
      wb_valid_o <= 1'b0;
    end
  end

endmodule

// ==== rtl/ex_top.sv ====
//////////////////////////////////////////////////
// Execute stage top with plain vector ports
// unit_i 2'd3 is decoded as the ALU
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid_i,
  input  logic [1:0]             unit_i,
  input  logic [3:0]             op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_RADDR_W-1:0] rd_i,
  input  logic                   kill_i,
  input  logic                   halt_i,
  input  logic                   wb_ready_i,
  output logic                   ex_ready_o,
  output logic                   branch_taken_o,
  output logic                   wb_valid_o,
  output logic [`EX_RADDR_W-1:0] wb_rd_o,
  output logic [`EX_XLEN-1:0]    wb_wdata_o
);
  import ex_pkg::*;

  // Vectors take on the stage's types here
  ex_stage u_ex_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .unit_i         (ex_unit_e'(unit_i)),
    .op_i           (ex_op_u'(op_i)),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .rd_i           (rd_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .wb_ready_i     (wb_ready_i),
    .ex_ready_o     (ex_ready_o),
    .branch_taken_o (branch_taken_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_o        (wb_rd_o),
    .wb_wdata_o     (wb_wdata_o)
  );

endmodule

// ==== verif/ex_props.sv ====
//////////////////////////////////////////////////
// Stage handshake and reset properties
// Bound into every ex_stage instance
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   halt_i,
  input logic                   kill_i,
  input logic                   wb_ready_i,
  input logic                   ex_ready_o,
  input logic                   wb_valid_o,
  input logic [`EX_RADDR_W-1:0] wb_rd_o,
  input logic [`EX_XLEN-1:0]    wb_wdata_o
);

  // Register stays empty while reset is held
  reset_wb_idle: assert property (@(posedge clk) !rst_n |-> !wb_valid_o)
    else $error("wb_valid_o high during reset");

  // A stalled result keeps its place in the EX/WB register
  wb_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> ($stable(wb_valid_o) && $stable(wb_rd_o)
                                     && $stable(wb_wdata_o)))
    else $error("write-back outputs changed while stalled");

  // Halt blocks the source unless the op is being killed
  halt_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_i && !kill_i) |-> !ex_ready_o)
    else $error("ex_ready_o high under halt");

endmodule

bind ex_stage ex_props u_ex_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .halt_i     (halt_i),
  .kill_i     (kill_i),
  .wb_ready_i (wb_ready_i),
  .ex_ready_o (ex_ready_o),
  .wb_valid_o (wb_valid_o),
  .wb_rd_o    (wb_rd_o),
  .wb_wdata_o (wb_wdata_o)
);

// ==== verif/ex_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the execute stage top level
// Inputs change 1 ns after the rising edge and
// outputs are sampled at the falling edge
// One operation is presented at a time
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_tb;
  import ex_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 52296;
  // Operations per test
  localparam int N_ALU      = 200;
  localparam int N_MUL      = 76;
  localparam int N_DIV      = 64;
  localparam int N_MIX      = 150;
  localparam int N_KILL     = 19;
  localparam int TOTAL_OPS  = N_ALU + N_MUL + N_DIV + N_MIX + N_KILL;
  // Cycles one operation may wait for acceptance
  localparam int OP_TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid_i;
  logic [1:0]             unit_i;
  logic [3:0]             op_i;
  logic [`EX_XLEN-1:0]    operand_a_i;
  logic [`EX_XLEN-1:0]    operand_b_i;
  logic [`EX_RADDR_W-1:0] rd_i;
  logic                   kill_i;
  logic                   halt_i;
  logic                   wb_ready_i;
  logic                   ex_ready_o;
  logic                   branch_taken_o;
  logic                   wb_valid_o;
  logic [`EX_RADDR_W-1:0] wb_rd_o;
  logic [`EX_XLEN-1:0]    wb_wdata_o;

  // Expected results with the oldest first
  logic [`EX_XLEN-1:0]    exp_data_q[$];
  logic [`EX_RADDR_W-1:0] exp_rd_q[$];
  string                  exp_test_q[$];

  string                  cur_test;
  int                     err_count;
  int                     err_mark;
  int                     tests_passed;
  int                     tests_failed;
  bit                     bp_en;
  // Monitor state
  string                  mon_test;
  logic [`EX_XLEN-1:0]    mon_data;
  logic [`EX_RADDR_W-1:0] mon_rd;
  bit                     stall_seen;
  logic [`EX_XLEN-1:0]    stall_data;
  logic [`EX_RADDR_W-1:0] stall_rd;

  logic [`EX_XLEN-1:0] edge_vals [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

  ex_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .unit_i         (unit_i),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .rd_i           (rd_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .wb_ready_i     (wb_ready_i),
    .ex_ready_o     (ex_ready_o),
    .branch_taken_o (branch_taken_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_o        (wb_rd_o),
    .wb_wdata_o     (wb_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////

  // Only the four compares set the branch flag
  function automatic logic ref_cmp(input logic [3:0] op, input logic [31:0] a,
                                   input logic [31:0] b);
    if (op == ALU_SLT) return $signed(a) < $signed(b);
    if (op == ALU_SLTU) return a < b;
    if (op == ALU_EQ) return a == b;
    if (op == ALU_NE) return a != b;
    return 1'b0;
  endfunction

  function automatic logic [31:0] ex_ref_model(input logic [1:0] unit, input logic [3:0] op,
                                               input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        prod;
    logic               ovf;
    logic [31:0]        res;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    res = '0;
    if (unit == UNIT_MUL) begin
      // Extend to 64 bits by form so the product is exact modulo 2^64
      ea   = (op[1:0] == MD_MULH || op[1:0] == MD_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
      eb   = (op[1:0] == MD_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
      prod = ea * eb;
      res  = (op[1:0] == MD_MUL) ? prod[31:0] : prod[63:32];
    end else if (unit == UNIT_DIV) begin
      case (op[1:0])
        MD_DIV: begin
          if (b == 0) res = '1;
          else if (ovf) res = a;
          else res = sa / sb;
        end
        MD_DIVU: res = (b == 0) ? '1 : a / b;
        MD_REM: begin
          if (b == 0) res = a;
          else if (ovf) res = '0;
          else res = sa % sb;
        end
        default: res = (b == 0) ? a : a % b;
      endcase
    end else begin
      case (op)
        ALU_SUB: res = a - b;
        ALU_AND: res = a & b;
        ALU_OR:  res = a | b;
        ALU_XOR: res = a ^ b;
        ALU_SLL: res = a << b[4:0];
        ALU_SRL: res = a >> b[4:0];
        ALU_SRA: res = $signed(a) >>> b[4:0];
        ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: res = {31'd0, ref_cmp(op, a, b)};
        default: res = a + b;
      endcase
    end
    return res;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", what, exp, act);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////
  // Monitor and write-back readiness
  ////////////////////////////////////////////////

  initial begin
    stall_seen = 1'b0;
    // First sample follows the first rising edge
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        // EX/WB register is cleared throughout reset
        check_val({cur_test, "/reset_wb_valid"}, 32'd0, 32'(wb_valid_o));
        check_val({cur_test, "/reset_wb_rd"}, 32'd0, 32'(wb_rd_o));
        check_val({cur_test, "/reset_wb_wdata"}, 32'd0, wb_wdata_o);
      end else begin
        // Held outputs must not move while write-back stalls
        if (stall_seen) begin
          check_val({cur_test, "/stall_data"}, stall_data, wb_wdata_o);
          check_val({cur_test, "/stall_rd"}, 32'(stall_rd), 32'(wb_rd_o));
        end
        stall_seen = wb_valid_o && !wb_ready_i;
        stall_data = wb_wdata_o;
        stall_rd   = wb_rd_o;
        if (wb_valid_o && wb_ready_i) begin
          if (exp_data_q.size() == 0) begin
            $display("ERROR: %s result for x%0d arrived with nothing outstanding",
                     cur_test, wb_rd_o);
            err_count++;
          end else begin
            mon_test = exp_test_q.pop_front();
            mon_data = exp_data_q.pop_front();
            mon_rd   = exp_rd_q.pop_front();
            check_val(mon_test, mon_data, wb_wdata_o);
            check_val({mon_test, "/rd"}, 32'(mon_rd), 32'(wb_rd_o));
          end
        end
      end
    end
  end

  // Random stalls from write-back when enabled
  initial begin
    wb_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      wb_ready_i = bp_en ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  initial begin
    #((TOTAL_OPS * 40 + RST_CYCLES) * CLK_PERIOD);
    $display("ERROR: watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////

  // Holds one op until the stage takes it with an optional kill or halt
  task automatic drive_op(input logic [1:0] unit, input logic [3:0] op, input logic [31:0] a,
                          input logic [31:0] b, input int kill_after, input int halt_cycles);
    int  cycles;
    bit  done;
    cycles        = 0;
    done          = 1'b0;
    unit_i        = unit;
    op_i          = op;
    operand_a_i   = a;
    operand_b_i   = b;
    rd_i          = 5'($urandom);
    instr_valid_i = 1'b1;
    kill_i        = (kill_after == 0);
    halt_i        = (halt_cycles > 0);
    while (!done) begin
      @(negedge clk);
      if (unit == UNIT_ALU) begin
        check_val({cur_test, "/branch"}, 32'(ref_cmp(op, a, b)), 32'(branch_taken_o));
      end
      if (halt_i && !kill_i) begin
        check_val({cur_test, "/halt_ready"}, 32'd0, 32'(ex_ready_o));
        check_val({cur_test, "/halt_wb_valid"}, 32'd0, 32'(wb_valid_o));
      end
      // Ready at this point means the op leaves at the next edge
      if (ex_ready_o) begin
        if (!kill_i) begin
          exp_data_q.push_back(ex_ref_model(unit, op, a, b));
          exp_rd_q.push_back(rd_i);
          exp_test_q.push_back(cur_test);
        end
        done = 1'b1;
      end else if (cycles >= OP_TIMEOUT) begin
        $display("ERROR: %s operation was never accepted by the stage", cur_test);
        err_count++;
        done = 1'b1;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (done) begin
        instr_valid_i = 1'b0;
        kill_i        = 1'b0;
        halt_i        = 1'b0;
      end else begin
        if (halt_cycles > 0 && cycles >= halt_cycles) halt_i = 1'b0;
        if (kill_after > 0 && cycles >= kill_after) kill_i = 1'b1;
      end
    end
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < 100) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      $display("ERROR: %0d expected results of %s never arrived", exp_data_q.size(), cur_test);
      err_count++;
      exp_data_q.delete();
      exp_rd_q.delete();
      exp_test_q.delete();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = err_count;
  endtask

  task automatic end_test(input int n_ops);
    drain_results();
    // Late or extra results still show up here
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    if (err_count == err_mark) begin
      tests_passed++;
      $display("test %-12s PASS  %0d ops", cur_test, n_ops);
    end else begin
      tests_failed++;
      $display("test %-12s FAIL  %0d errors", cur_test, err_count - err_mark);
    end
  endtask

  ////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////

  initial begin
    logic [1:0]  unit;
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    unit_i        = '0;
    op_i          = '0;
    operand_a_i   = '0;
    operand_b_i   = '0;
    rd_i          = '0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    bp_en         = 1'b0;
    err_count     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    cur_test      = "reset";
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // ALU ops with shifts by 0 and 31 and equal operands forced now and then
    begin_test("alu_random");
    for (int i = 0; i < N_ALU; i++) begin
      op = 4'($urandom_range(11));
      a  = $urandom;
      b  = $urandom;
      if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA) begin
        if (i % 4 == 0) b[4:0] = 5'd0;
        else if (i % 4 == 1) b[4:0] = 5'd31;
      end
      if (ref_cmp(op, a, a) !== ref_cmp(op, a, b) && i % 3 == 0) b = a;
      drive_op(UNIT_ALU, op, a, b, -1, 0);
    end
    end_test(N_ALU);

    // Multiplier edge pairs then random operands per form
    begin_test("mul_forms");
    for (int md = 0; md < 4; md++) begin
      for (int ia = 0; ia < 3; ia++) begin
        for (int ib = 0; ib < 3; ib++) begin
          drive_op(UNIT_MUL, 4'(md), edge_vals[ia], edge_vals[ib], -1, 0);
        end
      end
      for (int k = 0; k < 10; k++) drive_op(UNIT_MUL, 4'(md), $urandom, $urandom, -1, 0);
    end
    end_test(N_MUL);

    // Divider with zero divisor, overflow, small, large and random divisors
    begin_test("div_forms");
    for (int md = 0; md < 4; md++) begin
      drive_op(UNIT_DIV, 4'(md), $urandom, 32'd0, -1, 0);
      drive_op(UNIT_DIV, 4'(md), 32'h8000_0000, 32'hffff_ffff, -1, 0);
      for (int k = 0; k < 14; k++) begin
        a = $urandom;
        if (k < 4) b = $urandom_range(15, 1);
        else if (k < 8) b = $urandom | 32'h8000_0000;
        else b = $urandom >> $urandom_range(31);
        drive_op(UNIT_DIV, 4'(md), a, b, -1, 0);
      end
    end
    end_test(N_DIV);

    // Mixed traffic with write-back stalls
    begin_test("backpressure");
    bp_en = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      unit = 2'($urandom_range(2));
      op   = (unit == UNIT_ALU) ? 4'($urandom_range(11)) : 4'($urandom_range(3));
      a    = $urandom;
      b    = (unit == UNIT_DIV) ? $urandom >> $urandom_range(31) : $urandom;
      drive_op(unit, op, a, b, -1, 0);
    end
    bp_en = 1'b0;
    end_test(N_MIX);

    // Killed ops vanish and each unit still works afterwards
    begin_test("kill_halt");
    for (int r = 0; r < 3; r++) begin
      drive_op(UNIT_ALU, 4'($urandom_range(11)), $urandom, $urandom, 0, 0);
      drive_op(UNIT_MUL, 4'($urandom_range(3)), $urandom, $urandom, r % 2, 0);
      drive_op(UNIT_DIV, 4'($urandom_range(3)), $urandom, $urandom, r, 0);
    end
    drive_op(UNIT_ALU, ALU_XOR, $urandom, $urandom, -1, 0);
    drive_op(UNIT_MUL, MD_MULHSU, $urandom, $urandom, -1, 0);
    drive_op(UNIT_DIV, MD_REM, $urandom, $urandom, -1, 0);
    // Divide by one runs the longest so it is cut mid-loop
    drive_op(UNIT_DIV, MD_DIVU, $urandom, 32'd1, 6, 0);
    drive_op(UNIT_DIV, MD_DIV, $urandom, $urandom_range(15, 1), -1, 0);
    drive_op(UNIT_DIV, MD_REMU, $urandom, 32'd1, 9, 0);
    drive_op(UNIT_DIV, MD_REM, $urandom, $urandom >> 4, -1, 0);
    // Halt with an empty pipe lets nothing out
    for (int u = 0; u < 3; u++) begin
      drain_results();
      drive_op(2'(u), (u == 0) ? ALU_ADD : MD_DIV, $urandom, $urandom >> 8, -1, 8);
    end
    end_test(N_KILL);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/div_alu_if.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_div.sv
rtl/ex_stage.sv
rtl/ex_top.sv
verif/ex_props.sv
verif/ex_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_pkg.sv
      - rtl/div_alu_if.sv
      - rtl/ex_alu.sv
      - rtl/ex_mult.sv
      - rtl/ex_div.sv
      - rtl/ex_stage.sv
      - rtl/ex_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/ex_props.sv
      - verif/ex_tb.sv
